/* design/ifetch_pkg.sv */
// Shared definitions for the instruction-fetch stage
// Address and instruction widths, reset vector
// Major opcodes for the 32-bit and compressed branch decode
// Instruction word union with its 32-bit and compressed views

`default_nettype none

package ifetch_pkg;

  ////////////////////
  // Widths
  localparam int pc_size    = 32;
  localparam int instr_size = 32;

  // Program counter or address addend
  typedef logic [pc_size-1:0] pc_t;

  // First fetch address after reset
  localparam pc_t reset_pc = 32'h0000_1000;

  ////////////////////
  // Opcodes
  // 32-bit major opcodes used by the predictor
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // Compressed quadrant 1 and its jump and branch function codes
  localparam logic [1:0] rvc_q1          = 2'b01;
  localparam logic [2:0] rvc_funct3_j    = 3'b101;
  localparam logic [2:0] rvc_funct3_beqz = 3'b110;
  localparam logic [2:0] rvc_funct3_bnez = 3'b111;

  ////////////////////
  // Instruction word
  // Standard 32-bit encoding fields
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  // Compressed encoding in the low half word
  // Body holds bits 12:2 where the scrambled immediates live
  typedef struct packed {
    logic [15:0] unused;
    logic [2:0]  funct3;
    logic [10:0] body;
    logic [1:0]  op;
  } rvc_fields_t;

  // Low two bits equal to 3 select the 32-bit view
  typedef union packed {
    rv32_fields_t rv32;
    rvc_fields_t  rvc;
  } instr_t;

endpackage

`default_nettype wire

/* design/ifetch_minidec.sv */
// Mini-decoder of the fetch stage
// Instruction length, JAL and conditional branch detection
// Sign-extended jump and branch offsets for both encodings

`timescale 1ns/1ps
`default_nettype none

module ifetch_minidec (
  input  ifetch_pkg::instr_t instr,
  output logic               dec_rv32,
  output logic               dec_bjp,
  output logic               dec_jal,
  output logic               dec_bxx,
  output ifetch_pkg::pc_t    dec_bjp_imm
);

  ////////////////////
  // Length and type
  logic        rvc_q1_hit;
  logic        rv32_jal;
  logic        rv32_bxx;
  logic        rvc_j;
  logic        rvc_bxx;
  logic [20:0] jal_imm;
  logic [12:0] bxx_imm;
  logic [11:0] cj_imm;
  logic [8:0]  cb_imm;

  // Both low bits set means a full 32-bit word
  assign dec_rv32 = (instr.rv32.opcode[1:0] == 2'b11);

  assign rv32_jal = dec_rv32 & (instr.rv32.opcode == ifetch_pkg::opc_jal);
  assign rv32_bxx = dec_rv32 & (instr.rv32.opcode == ifetch_pkg::opc_branch);

  // Compressed forms only count when the word is really 16 bits
  assign rvc_q1_hit = ~dec_rv32 & (instr.rvc.op == ifetch_pkg::rvc_q1);
  assign rvc_j      = rvc_q1_hit & (instr.rvc.funct3 == ifetch_pkg::rvc_funct3_j);
  assign rvc_bxx    = rvc_q1_hit & ((instr.rvc.funct3 == ifetch_pkg::rvc_funct3_beqz)
                                  | (instr.rvc.funct3 == ifetch_pkg::rvc_funct3_bnez));

  assign dec_jal = rv32_jal | rvc_j;
  assign dec_bxx = rv32_bxx | rvc_bxx;
  assign dec_bjp = dec_jal | dec_bxx;

  ////////////////////
  // Immediates
  // J-type offset, imm[20|10:1|11|19:12] in bits 31:12
  assign jal_imm = {instr.rv32.funct7[6], instr.rv32.rs1, instr.rv32.funct3,
                    instr.rv32.rs2[0], instr.rv32.funct7[5:0], instr.rv32.rs2[4:1], 1'b0};

  // B-type offset split between funct7 and rd
  assign bxx_imm = {instr.rv32.funct7[6], instr.rv32.rd[0], instr.rv32.funct7[5:0],
                    instr.rv32.rd[4:1], 1'b0};

  // C.J offset, imm[11|4|9:8|10|6|7|3:1|5] across the body
  assign cj_imm = {instr.rvc.body[10], instr.rvc.body[6], instr.rvc.body[8:7],
                   instr.rvc.body[4], instr.rvc.body[5], instr.rvc.body[0],
                   instr.rvc.body[9], instr.rvc.body[3:1], 1'b0};

  // C.BEQZ and C.BNEZ offset, imm[8|4:3] then imm[7:6|2:1|5]
  assign cb_imm = {instr.rvc.body[10], instr.rvc.body[4:3], instr.rvc.body[0],
                   instr.rvc.body[9:8], instr.rvc.body[2:1], 1'b0};

  // Pick the offset of whichever form was decoded
  always_comb begin
    dec_bjp_imm = '0;
    if (rv32_jal) begin
      dec_bjp_imm = {{(ifetch_pkg::pc_size-21){jal_imm[20]}}, jal_imm};
    end else if (rv32_bxx) begin
      dec_bjp_imm = {{(ifetch_pkg::pc_size-13){bxx_imm[12]}}, bxx_imm};
    end else if (rvc_j) begin
      dec_bjp_imm = {{(ifetch_pkg::pc_size-12){cj_imm[11]}}, cj_imm};
    end else if (rvc_bxx) begin
      dec_bjp_imm = {{(ifetch_pkg::pc_size-9){cb_imm[8]}}, cb_imm};
    end
  end

endmodule

`default_nettype wire

/* design/ifetch_pc_gen.sv */
// Next-PC generation for the fetch stage
// Static predictor, flush and delayed flush, reset request
// Outstanding-request tracking and halt acknowledge

`timescale 1ns/1ps
`default_nettype none

module ifetch_pc_gen (
  input  logic            clk,
  input  logic            reset,
  output logic            ifu_req_valid,
  input  logic            ifu_req_ready,
  output ifetch_pkg::pc_t ifu_req_pc,
  output logic            ifu_req_seq,
  input  logic            ifu_rsp_valid,
  output logic            ifu_rsp_ready,
  input  logic            ir_ready,
  input  logic            dec_rv32,
  input  logic            dec_bjp,
  input  logic            dec_jal,
  input  logic            dec_bxx,
  input  ifetch_pkg::pc_t dec_bjp_imm,
  input  logic            pipe_flush_req,
  input  ifetch_pkg::pc_t pipe_flush_add_op1,
  input  ifetch_pkg::pc_t pipe_flush_add_op2,
  input  logic            ifu_halt_req,
  output logic            ifu_halt_ack,
  output ifetch_pkg::pc_t pc_r,
  output logic            prdt_taken,
  output logic            flush_active
);

  logic            req_hsked;
  logic            rsp_hsked;
  logic            reset_flag_r;
  logic            reset_req_r;
  logic            dly_flush_r;
  logic            resume_r;
  logic            resume_set;
  logic            out_flag_r;
  logic            halt_ack_r;
  logic            no_outs;
  logic            new_req_condi;
  logic            req_block;
  logic            hold_pc;
  logic            pc_ena;
  ifetch_pkg::pc_t pc_incr;
  ifetch_pkg::pc_t add_op1;
  ifetch_pkg::pc_t add_op2;
  ifetch_pkg::pc_t pc_sum;

  assign req_hsked = ifu_req_valid & ifu_req_ready;
  assign rsp_hsked = ifu_rsp_valid & ifu_rsp_ready;

  // A flush counts from its pulse until the delayed copy is issued
  assign flush_active = pipe_flush_req | dly_flush_r;

  ////////////////////
  // Static prediction
  // JAL always taken, Bxx taken only when the offset is negative
  assign prdt_taken = ifu_rsp_valid & dec_bjp & (dec_jal | (dec_bxx & dec_bjp_imm[31]));

  // Response handshaked while halted, next PC parked in pc_r
  assign resume_set = rsp_hsked & ~req_hsked & ~flush_active;
  assign hold_pc    = dly_flush_r | resume_r;

  ////////////////////
  // Next PC
  assign pc_incr = dec_rv32 ? ifetch_pkg::pc_t'(4) : ifetch_pkg::pc_t'(2);

  // Flush, parked PC, taken branch, reset vector, then sequential
  always_comb begin
    if (pipe_flush_req) begin
      add_op1 = pipe_flush_add_op1;
      add_op2 = pipe_flush_add_op2;
    end else if (hold_pc) begin
      add_op1 = pc_r;
      add_op2 = '0;
    end else if (prdt_taken) begin
      add_op1 = pc_r;
      add_op2 = dec_bjp_imm;
    end else if (reset_req_r) begin
      add_op1 = ifetch_pkg::reset_pc;
      add_op2 = '0;
    end else begin
      add_op1 = pc_r;
      add_op2 = pc_incr;
    end
  end

  assign pc_sum     = add_op1 + add_op2;
  assign ifu_req_pc = {pc_sum[ifetch_pkg::pc_size-1:1], 1'b0};
  assign ifu_req_seq = ~flush_active & ~reset_req_r & ~prdt_taken;

  ////////////////////
  // Request control
  // One in flight, a new one may go out as the old response returns
  assign new_req_condi = ~out_flag_r | rsp_hsked;
  assign no_outs       = ~out_flag_r | ifu_rsp_valid;

  // Nothing is issued while halt is requested or still acknowledged
  assign req_block = ifu_halt_req | halt_ack_r | reset_flag_r;

  assign ifu_req_valid = new_req_condi & ~req_block;

  // A flush swallows the response, otherwise IR and request side must both take it
  assign ifu_rsp_ready = flush_active | (ir_ready & ifu_req_ready);

  assign pc_ena = req_hsked | pipe_flush_req | resume_set;

  assign ifu_halt_ack = halt_ack_r;

  always_ff @(posedge clk) begin
    if (reset) begin
      reset_flag_r <= 1'b1;
      reset_req_r  <= 1'b0;
      dly_flush_r  <= 1'b0;
      resume_r     <= 1'b0;
      out_flag_r   <= 1'b0;
      halt_ack_r   <= 1'b0;
      pc_r         <= ifetch_pkg::reset_pc;
    end else begin
      reset_flag_r <= 1'b0;
      // Raised once right after reset, dropped when the vector is fetched
      reset_req_r  <= (reset_flag_r & ~reset_req_r) | (reset_req_r & ~req_hsked);
      // Flush that could not be issued in its own cycle
      dly_flush_r  <= (pipe_flush_req & ~req_hsked) | (dly_flush_r & ~req_hsked);
      resume_r     <= resume_set | (resume_r & ~req_hsked & ~pipe_flush_req);
      // Set wins over clear when a response and new request coincide
      out_flag_r   <= req_hsked | (out_flag_r & ~rsp_hsked);
      // Four-phase ack, up once drained, down after the request drops
      halt_ack_r   <= (ifu_halt_req & no_outs) | (halt_ack_r & ifu_halt_req);
      if (pc_ena) begin
        pc_r <= ifu_req_pc;
      end
    end
  end

  ////////////////////
  // Checks
  a_req_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(ifu_req_valid))
    else $error("ifu_req_valid is unknown");

  // Only the flush adder may land on an odd address
  a_req_pc_even: assert property (@(posedge clk) disable iff (reset)
    (ifu_req_valid & ~pipe_flush_req) |-> (pc_sum[0] == 1'b0))
    else $error("odd fetch address %h", pc_sum);

  // Memory may only answer a request that was actually taken
  a_rsp_needs_req: assert property (@(posedge clk) disable iff (reset)
    ifu_rsp_valid |-> out_flag_r)
    else $error("response without outstanding request");

endmodule

`default_nettype wire

/* design/ifetch_ir_stage.sv */
// Instruction register between fetch and execute
// Holds instruction, PC, bus error and prediction bit
// Valid/ready handshake towards execute

`timescale 1ns/1ps
`default_nettype none

module ifetch_ir_stage (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              ifu_rsp_valid,
  input  logic                              ifu_rsp_ready,
  input  ifetch_pkg::instr_t                ifu_rsp_instr,
  input  logic                              ifu_rsp_err,
  input  ifetch_pkg::pc_t                   pc_r,
  input  logic                              prdt_taken,
  input  logic                              flush_active,
  output logic                              ir_ready,
  output logic                              ifu_o_valid,
  input  logic                              ifu_o_ready,
  output logic [ifetch_pkg::instr_size-1:0] ifu_o_ir,
  output ifetch_pkg::pc_t                   ifu_o_pc,
  output logic                              ifu_o_buserr,
  output logic                              ifu_o_prdt_taken
);

  logic               ir_valid_r;
  logic               ir_valid_set;
  logic               ir_valid_clr;
  logic               o_hsked;
  ifetch_pkg::instr_t ir_r;
  ifetch_pkg::pc_t    ir_pc_r;
  logic               ir_err_r;
  logic               ir_prdt_r;

  assign o_hsked = ifu_o_valid & ifu_o_ready;

  ////////////////////
  // Valid control
  // Load only fetched words that a flush has not cancelled
  assign ir_valid_set = ifu_rsp_valid & ifu_rsp_ready & ~flush_active;

  // Drain on consumption, drop on flush
  assign ir_valid_clr = o_hsked | (flush_active & ir_valid_r);

  // Empty or emptying this cycle
  assign ir_ready = ~ir_valid_r | ir_valid_clr;

  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid_r <= 1'b0;
    end else begin
      ir_valid_r <= ir_valid_set | (ir_valid_r & ~ir_valid_clr);
    end
  end

  ////////////////////
  // Payload
  // pc_r still holds this word's address on the handshake edge
  always_ff @(posedge clk) begin
    if (ir_valid_set) begin
      ir_r      <= ifu_rsp_instr;
      ir_pc_r   <= pc_r;
      ir_err_r  <= ifu_rsp_err;
      ir_prdt_r <= prdt_taken;
    end
  end

  assign ifu_o_valid      = ir_valid_r;
  assign ifu_o_ir         = ir_r;
  assign ifu_o_pc         = ir_pc_r;
  assign ifu_o_buserr     = ir_err_r;
  assign ifu_o_prdt_taken = ir_prdt_r;

  ////////////////////
  // Checks
  // Stalled entry must not change under execute's feet
  a_ir_stable: assert property (@(posedge clk) disable iff (reset)
    (ifu_o_valid & ~ifu_o_ready & ~flush_active) |=>
      (ifu_o_valid & $stable(ifu_o_ir) & $stable(ifu_o_pc)
       & $stable(ifu_o_buserr) & $stable(ifu_o_prdt_taken)))
    else $error("IR output changed while stalled, pc %h", ifu_o_pc);

endmodule

`default_nettype wire

/* design/ifetch_top.sv */
// Top level of the instruction-fetch stage
// Mini-decoder, PC generator and instruction register

`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
  input  logic                              clk,
  input  logic                              reset,
  // Fetch request to memory
  output logic                              ifu_req_valid,
  input  logic                              ifu_req_ready,
  output ifetch_pkg::pc_t                   ifu_req_pc,
  output logic                              ifu_req_seq,
  // Fetch response from memory
  input  logic                              ifu_rsp_valid,
  output logic                              ifu_rsp_ready,
  input  ifetch_pkg::instr_t                ifu_rsp_instr,
  input  logic                              ifu_rsp_err,
  // IR towards execute
  output logic                              ifu_o_valid,
  input  logic                              ifu_o_ready,
  output logic [ifetch_pkg::instr_size-1:0] ifu_o_ir,
  output ifetch_pkg::pc_t                   ifu_o_pc,
  output logic                              ifu_o_buserr,
  output logic                              ifu_o_prdt_taken,
  // Flush from commit
  input  logic                              pipe_flush_req,
  input  ifetch_pkg::pc_t                   pipe_flush_add_op1,
  input  ifetch_pkg::pc_t                   pipe_flush_add_op2,
  // Halt handshake
  input  logic                              ifu_halt_req,
  output logic                              ifu_halt_ack
);

  logic            dec_rv32;
  logic            dec_bjp;
  logic            dec_jal;
  logic            dec_bxx;
  ifetch_pkg::pc_t dec_bjp_imm;
  ifetch_pkg::pc_t pc_r;
  logic            prdt_taken;
  logic            flush_active;
  logic            ir_ready;

  // Decode straight off the response bus
  ifetch_minidec u_minidec (
    .instr       (ifu_rsp_instr),
    .dec_rv32    (dec_rv32),
    .dec_bjp     (dec_bjp),
    .dec_jal     (dec_jal),
    .dec_bxx     (dec_bxx),
    .dec_bjp_imm (dec_bjp_imm)
  );

  ifetch_pc_gen u_pc_gen (
    .clk                (clk),
    .reset              (reset),
    .ifu_req_valid      (ifu_req_valid),
    .ifu_req_ready      (ifu_req_ready),
    .ifu_req_pc         (ifu_req_pc),
    .ifu_req_seq        (ifu_req_seq),
    .ifu_rsp_valid      (ifu_rsp_valid),
    .ifu_rsp_ready      (ifu_rsp_ready),
    .ir_ready           (ir_ready),
    .dec_rv32           (dec_rv32),
    .dec_bjp            (dec_bjp),
    .dec_jal            (dec_jal),
    .dec_bxx            (dec_bxx),
    .dec_bjp_imm        (dec_bjp_imm),
    .pipe_flush_req     (pipe_flush_req),
    .pipe_flush_add_op1 (pipe_flush_add_op1),
    .pipe_flush_add_op2 (pipe_flush_add_op2),
    .ifu_halt_req       (ifu_halt_req),
    .ifu_halt_ack       (ifu_halt_ack),
    .pc_r               (pc_r),
    .prdt_taken         (prdt_taken),
    .flush_active       (flush_active)
  );

  ifetch_ir_stage u_ir_stage (
    .clk              (clk),
    .reset            (reset),
    .ifu_rsp_valid    (ifu_rsp_valid),
    .ifu_rsp_ready    (ifu_rsp_ready),
    .ifu_rsp_instr    (ifu_rsp_instr),
    .ifu_rsp_err      (ifu_rsp_err),
    .pc_r             (pc_r),
    .prdt_taken       (prdt_taken),
    .flush_active     (flush_active),
    .ir_ready         (ir_ready),
    .ifu_o_valid      (ifu_o_valid),
    .ifu_o_ready      (ifu_o_ready),
    .ifu_o_ir         (ifu_o_ir),
    .ifu_o_pc         (ifu_o_pc),
    .ifu_o_buserr     (ifu_o_buserr),
    .ifu_o_prdt_taken (ifu_o_prdt_taken)
  );

endmodule

`default_nettype wire

/* sim/fetch_mem_model.sv */
// Instruction memory responder for the fetch testbench
// Random ready and latency, program words computed from the address
// Reference jump kind and offset travel beside each response

`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model (
  input  logic               clk,
  input  logic               reset,
  input  logic [31:0]        rnd,
  input  logic               ifu_req_valid,
  output logic               ifu_req_ready,
  input  ifetch_pkg::pc_t    ifu_req_pc,
  output logic               ifu_rsp_valid,
  input  logic               ifu_rsp_ready,
  output ifetch_pkg::instr_t ifu_rsp_instr,
  output logic               ifu_rsp_err,
  output logic [1:0]         rsp_kind,
  output ifetch_pkg::pc_t    rsp_off
);

  logic            take;
  logic            give;
  logic            rst_s;
  logic            pending;
  logic [1:0]      cnt;
  logic [31:0]     r_s;
  ifetch_pkg::pc_t a_s;
  ifetch_pkg::pc_t addr;

  ////////////////////
  // Program
  // Kind 1 is a jump, kind 2 a conditional branch, 0 anything else
  task automatic load_word(input ifetch_pkg::pc_t a);
    logic [2:0]      sel;
    logic [15:0]     hi;
    ifetch_pkg::pc_t o;
    sel = a[3:1] ^ a[6:4];
    hi  = a[31:16] ^ a[15:0];
    o   = ifetch_pkg::pc_t'({a[5:2], 2'b00}) + 8;
    // Bit 7 of the address picks a backward target
    if (a[7]) o = -o;
    rsp_kind = 2'd0;
    rsp_off  = o;
    case (sel)
      3'd2: ifu_rsp_instr = {hi, 3'b000, a[11:1], 2'b00};
      3'd3: begin
        ifu_rsp_instr = {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
        rsp_kind = 2'd1;
      end
      3'd4: begin
        ifu_rsp_instr = {o[12], o[10:5], 5'd2, 5'd3, 3'b000, o[4:1], o[11], 7'b1100011};
        rsp_kind = 2'd2;
      end
      3'd5: begin
        ifu_rsp_instr = {hi, 3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
        rsp_kind = 2'd1;
      end
      3'd6: begin
        ifu_rsp_instr = {hi, 3'b111, o[8], o[4:3], 3'b010, o[7:6], o[2:1], o[5], 2'b01};
        rsp_kind = 2'd2;
      end
      // C.ADDI sits in quadrant 1 but is no jump
      3'd7: ifu_rsp_instr = {hi, 3'b000, a[11:1], 2'b01};
      default: ifu_rsp_instr = {a[31:20], 5'd1, 3'b000, 5'd2, 7'b0010011};
    endcase
    ifu_rsp_err = &a[7:4];
  endtask

  ////////////////////
  // Responder
  initial begin
    ifu_req_ready = 1'b0;
    ifu_rsp_valid = 1'b0;
    ifu_rsp_instr = '0;
    ifu_rsp_err   = 1'b0;
    rsp_kind      = 2'd0;
    rsp_off       = '0;
    pending       = 1'b0;
    cnt           = 2'd0;
    addr          = '0;
    forever begin
      // Handshakes are settled by the falling edge
      @(negedge clk);
      rst_s = reset;
      r_s   = rnd;
      take  = ifu_req_valid & ifu_req_ready;
      give  = ifu_rsp_valid & ifu_rsp_ready;
      a_s   = ifu_req_pc;
      @(posedge clk);
      #2;
      if (rst_s) begin
        ifu_rsp_valid = 1'b0;
        pending       = 1'b0;
      end else begin
        if (give) ifu_rsp_valid = 1'b0;
        if (take) begin
          pending = 1'b1;
          addr    = a_s;
          cnt     = r_s[3:2];
        end else if (pending && cnt != 0) begin
          cnt = cnt - 1;
        end
        if (pending && cnt == 0) begin
          load_word(addr);
          ifu_rsp_valid = 1'b1;
          pending       = 1'b0;
        end
      end
      ifu_req_ready = r_s[0] | r_s[5];
    end
  end

endmodule

`default_nettype wire

/* sim/ifetch_tb.sv */
// Testbench for the instruction-fetch stage
// Clock, reset, random flush, halt and back-pressure stimulus
// Reference PC and IR tracking with checking assertions

`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

  localparam logic [31:0] seed       = 32'd27;
  localparam int          run_cycles = 4000;
  localparam int          wait_limit = 200;

  logic               clk;
  logic               reset;
  logic [31:0]        rnd;
  logic               ifu_req_valid;
  logic               ifu_req_ready;
  ifetch_pkg::pc_t    ifu_req_pc;
  logic               ifu_req_seq;
  logic               ifu_rsp_valid;
  logic               ifu_rsp_ready;
  ifetch_pkg::instr_t ifu_rsp_instr;
  logic               ifu_rsp_err;
  logic               ifu_o_valid;
  logic               ifu_o_ready;
  logic [31:0]        ifu_o_ir;
  ifetch_pkg::pc_t    ifu_o_pc;
  logic               ifu_o_buserr;
  logic               ifu_o_prdt_taken;
  logic               pipe_flush_req;
  ifetch_pkg::pc_t    pipe_flush_add_op1;
  ifetch_pkg::pc_t    pipe_flush_add_op2;
  logic               ifu_halt_req;
  logic               ifu_halt_ack;
  logic [1:0]         rsp_kind;
  ifetch_pkg::pc_t    rsp_off;

  // Reference state, updated at each falling edge
  ifetch_pkg::pc_t last_pc;
  ifetch_pkg::pc_t next_pc;
  logic            next_known;
  logic            seq_chk;
  logic            seq_exp;
  logic            pend_flush;
  logic            owed;
  logic            first_done;
  logic            prev_stall;
  logic            prev_ack;
  logic            prev_drained;
  logic [65:0]     prev_out;
  logic [65:0]     ir_q[$];
  int n_req = 0;
  int n_seq = 0;
  int n_jump = 0;
  int n_back = 0;
  int n_fwd = 0;
  int n_flush = 0;
  int n_halt = 0;
  int n_ir = 0;

  ifetch_top uut (.*);
  fetch_mem_model mem (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_with_failure($sformatf("error: %s is %h, expected %h", name, got, exp));
  endtask

  ////////////////////
  // Reference model
  always @(negedge clk) begin : track
    logic            req_hs;
    logic            rsp_hs;
    logic            o_hs;
    logic            flush_act;
    logic            taken;
    logic            drained_now;
    logic [65:0]     cur;
    logic [65:0]     ent;
    ifetch_pkg::pc_t incr;
    if (reset) begin
      next_pc    = ifetch_pkg::reset_pc;
      next_known = 1'b1;
      seq_chk    = 1'b1;
      seq_exp    = 1'b0;
      pend_flush = 1'b0;
      owed       = 1'b0;
      first_done = 1'b0;
      prev_stall = 1'b0;
      prev_ack   = 1'b0;
      ir_q.delete();
    end else begin
      req_hs      = ifu_req_valid & ifu_req_ready;
      rsp_hs      = ifu_rsp_valid & ifu_rsp_ready;
      o_hs        = ifu_o_valid & ifu_o_ready;
      flush_act   = pipe_flush_req | pend_flush;
      drained_now = ifu_halt_req & (~owed | ifu_rsp_valid);
      cur         = {ifu_o_ir, ifu_o_pc, ifu_o_buserr, ifu_o_prdt_taken};
      // Stalled IR entry holds
      if (prev_stall) begin
        assert (ifu_o_valid) else stop_with_failure("IR valid dropped while stalled");
        expect_value("ifu_o_ir", ifu_o_ir, prev_out[65:34]);
        expect_value("ifu_o_pc", ifu_o_pc, prev_out[33:2]);
        expect_value("ifu_o_buserr", ifu_o_buserr, prev_out[1]);
        expect_value("ifu_o_prdt_taken", ifu_o_prdt_taken, prev_out[0]);
      end
      // Ack only after a drained request
      if (ifu_halt_ack && !prev_ack) begin
        assert (prev_drained) else stop_with_failure("halt ack rose with a response still owed");
        n_halt++;
      end
      // IR entries in fetch order
      if (o_hs) begin
        assert (ir_q.size() != 0) else stop_with_failure("IR delivered an entry never fetched");
        ent = ir_q.pop_front();
        expect_value("ifu_o_ir", ifu_o_ir, ent[65:34]);
        expect_value("ifu_o_pc", ifu_o_pc, ent[33:2]);
        expect_value("ifu_o_buserr", ifu_o_buserr, ent[1]);
        expect_value("ifu_o_prdt_taken", ifu_o_prdt_taken, ent[0]);
        n_ir++;
      end else if (ifu_o_valid && flush_act) begin
        assert (ir_q.size() != 0) else stop_with_failure("flushed IR entry was never fetched");
        void'(ir_q.pop_front());
      end
      // Response decides the next PC unless a flush eats it
      if (rsp_hs) begin
        owed = 1'b0;
        if (!flush_act) begin
          taken   = (rsp_kind == 2'd1) | ((rsp_kind == 2'd2) & rsp_off[31]);
          incr    = (ifu_rsp_instr[1:0] == 2'b11) ? 32'd4 : 32'd2;
          next_pc = last_pc + (taken ? rsp_off : incr);
          next_known = 1'b1;
          seq_chk = ~taken;
          seq_exp = 1'b1;
          ir_q.push_back({ifu_rsp_instr, last_pc, ifu_rsp_err, taken});
          if (rsp_kind == 2'd0) n_seq++;
          if (rsp_kind == 2'd1) n_jump++;
          if (rsp_kind == 2'd2 && taken) n_back++;
          if (rsp_kind == 2'd2 && !taken) n_fwd++;
        end
      end
      if (pipe_flush_req) begin
        next_pc    = (pipe_flush_add_op1 + pipe_flush_add_op2) & ~32'd1;
        next_known = 1'b1;
        seq_chk    = 1'b1;
        seq_exp    = 1'b0;
        n_flush++;
      end
      if (req_hs) begin
        assert (next_known) else stop_with_failure("request issued with no known target");
        expect_value("ifu_req_pc", ifu_req_pc, next_pc);
        if (seq_chk) expect_value("ifu_req_seq", ifu_req_seq, seq_exp);
        last_pc    = ifu_req_pc;
        next_known = 1'b0;
        owed       = 1'b1;
        first_done = 1'b1;
        n_req++;
      end
      pend_flush   = flush_act & ~req_hs;
      prev_drained = drained_now;
      prev_ack     = ifu_halt_ack;
      prev_stall   = ifu_o_valid & ~ifu_o_ready & ~flush_act;
      prev_out     = cur;
    end
  end

  ////////////////////
  // Halt protocol
  a_no_fetch_in_halt: assert property (@(posedge clk) disable iff (reset)
    ifu_halt_ack |-> !(ifu_req_valid && ifu_req_ready))
    else stop_with_failure("request accepted while halt was acknowledged");

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ifu_halt_ack) |-> $past(ifu_halt_req))
    else stop_with_failure("halt ack rose without a request");

  a_ack_holds: assert property (@(posedge clk) disable iff (reset)
    (ifu_halt_ack && ifu_halt_req) |=> ifu_halt_ack)
    else stop_with_failure("halt ack fell before the request fell");

  task automatic next_cycle();
    @(posedge clk);
    #2;
    rnd = xorshift(rnd);
  endtask

  task automatic run_halt();
    int i;
    int req_mark;
    pipe_flush_req = 1'b0;
    ifu_halt_req   = 1'b1;
    ifu_o_ready    = 1'b1;
    for (i = 0; i < wait_limit && !ifu_halt_ack; i++) next_cycle();
    if (!ifu_halt_ack) stop_with_failure("halt request was never acknowledged");
    repeat (3) next_cycle();
    ifu_halt_req = 1'b0;
    for (i = 0; i < wait_limit && ifu_halt_ack; i++) next_cycle();
    if (ifu_halt_ack) stop_with_failure("halt ack stayed high after the request fell");
    // Fetching must pick up again
    req_mark = n_req;
    for (i = 0; i < wait_limit && n_req == req_mark; i++) next_cycle();
    if (n_req == req_mark) stop_with_failure("fetch did not resume after halt");
  endtask

  ////////////////////
  // Stimulus
  initial begin
    int i;
    reset              = 1'b1;
    rnd                = seed;
    ifu_o_ready        = 1'b0;
    pipe_flush_req     = 1'b0;
    pipe_flush_add_op1 = '0;
    pipe_flush_add_op2 = '0;
    ifu_halt_req       = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    for (i = 0; i < wait_limit && !first_done; i++) next_cycle();
    if (!first_done) stop_with_failure("no fetch request after reset");
    for (i = 0; i < run_cycles; i++) begin
      next_cycle();
      ifu_o_ready        = rnd[7] | rnd[8];
      pipe_flush_req     = (rnd[14:10] == 5'd0);
      pipe_flush_add_op1 = ifetch_pkg::reset_pc + ifetch_pkg::pc_t'(rnd[27:16]);
      pipe_flush_add_op2 = ifetch_pkg::pc_t'(rnd[31:28]);
      if (rnd[25:20] == 6'd9 && !pipe_flush_req) run_halt();
    end
    next_cycle();
    if (n_seq > 0 && n_jump > 0 && n_back > 0 && n_fwd > 0 && n_flush > 0
        && n_halt > 0 && n_ir > 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_with_failure("stimulus did not reach every kind of check");
    end
  end

endmodule

`default_nettype wire

/* project.f */
design/ifetch_pkg.sv
design/ifetch_minidec.sv
design/ifetch_pc_gen.sv
design/ifetch_ir_stage.sv
design/ifetch_top.sv
sim/fetch_mem_model.sv
sim/ifetch_tb.sv
